// ==== files.f ====
+incdir+src
src/bwt_types_pkg.sv
src/pipe_pkg.sv
src/occ_delay_line.sv
src/extend_decide_stage.sv
src/extend_update_stage.sv
src/mem_request_stage.sv
src/bwt_forward_top.sv
verification/bwt_forward_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f files.f --top-module bwt_forward_tb \
	-o bwt_forward_sim
out=$(./obj_dir/bwt_forward_sim)
echo "$out"
if echo "$out" | grep -qx "all tests passed"; then
	exit 0
fi
exit 1

// ==== src/bwt_forward_top.sv ====
`include "bwt_params.svh"

module bwt_forward_top (
	input  logic                     Clk_32UI,
	input  logic                     reset_BWT_extend,
	input  logic                     stall_i,
	input  pipe_pkg::fwd_req_t       req_i,
	input  bwt_types_pkg::word_t     primary_i,
	input  bwt_types_pkg::cand_set_t cand_i,
	output pipe_pkg::curr_wr_t       curr_wr_o,
	output pipe_pkg::ret_t           ret_o,
	output pipe_pkg::dram_req_t      dram_o,
	output pipe_pkg::fwd_req_t       next_req_o
);

	pipe_pkg::fwd_req_t       req_dly;  // lines up with cand_i
	pipe_pkg::upd_ctl_t       upd;
	bwt_types_pkg::cand_set_t cand_q;
	pipe_pkg::fwd_req_t       upd_req;
	bwt_types_pkg::word_t     k;
	bwt_types_pkg::word_t     l;
	bwt_types_pkg::word_t     k_dec;
	bwt_types_pkg::word_t     l_dec;

	// --------------------------------------------------
	// wait for the occurrence engine
	// --------------------------------------------------
	occ_delay_line #(
		.payload_t (pipe_pkg::fwd_req_t),
		.DEPTH     (`BWT_OCC_LATENCY),
		.RESET_VAL (pipe_pkg::BUBBLE_REQ)
	) occ_delay_line_i (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.stall_i          (stall_i),
		.d_i              (req_i),
		.q_o              (req_dly)
	);

	extend_decide_stage extend_decide_stage_i (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.stall_i          (stall_i),
		.req_i            (req_dly),
		.cand_i           (cand_i),
		.curr_wr_o        (curr_wr_o),
		.ret_o            (ret_o),
		.upd_o            (upd),
		.cand_o           (cand_q)
	);

	extend_update_stage extend_update_stage_i (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.stall_i          (stall_i),
		.upd_i            (upd),
		.cand_i           (cand_q),
		.req_o            (upd_req),
		.k_o              (k),
		.l_o              (l),
		.k_dec_o          (k_dec),
		.l_dec_o          (l_dec)
	);

	// --------------------------------------------------
	// next lookup
	// --------------------------------------------------
	mem_request_stage mem_request_stage_i (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.stall_i          (stall_i),
		.req_i            (upd_req),
		.k_i              (k),
		.l_i              (l),
		.k_dec_i          (k_dec),
		.l_dec_i          (l_dec),
		.primary_i        (primary_i),
		.dram_o           (dram_o),
		.next_req_o       (next_req_o)
	);

endmodule

// ==== src/bwt_params.svh ====
`ifndef BWT_PARAMS_SVH
`define BWT_PARAMS_SVH

// --------------------------------------------------
// read and queue geometry
// --------------------------------------------------
`define BWT_LEN             101 // read length in bases
`define BWT_READ_NUM_WIDTH  8
`define BWT_PTR_WIDTH       7   // curr queue pointer and forward position
`define BWT_QUERY_WIDTH     8
`define BWT_WORD_WIDTH      64  // one interval field

// occurrence engine sits outside, only its latency is kept here
`define BWT_OCC_LATENCY     13

// --------------------------------------------------
// dram line addressing
// --------------------------------------------------
`define BWT_ADDR_WIDTH      32
`define BWT_LINE_LO         7
`define BWT_LINE_HI         34

// --------------------------------------------------
// status codes
// --------------------------------------------------
`define BWT_STATUS_WIDTH    6
`define BWT_ST_INIT         6'd0
`define BWT_ST_RUN          6'd1
`define BWT_ST_BREAK        6'd2
`define BWT_ST_BCK_INI      6'd4  // hand-off code to backward search
`define BWT_ST_BUBBLE       6'd48 // empty pipeline slot

`endif

// ==== src/bwt_types_pkg.sv ====
`include "bwt_params.svh"

package bwt_types_pkg;

	// search state of one read
	typedef logic [`BWT_STATUS_WIDTH-1:0] status_t;

	typedef logic [`BWT_WORD_WIDTH-1:0] word_t;

	// --------------------------------------------------
	// bi-interval as used by the FM-index search
	// --------------------------------------------------
	typedef struct packed {
		word_t x0; // forward start
		word_t x1; // reverse start
		word_t x2; // interval size
	} interval_t;

	// interval plus its info word, which holds the end position
	typedef struct packed {
		interval_t intv;
		word_t     info;
	} ik_t;

	// ok[0..3], one candidate per base
	typedef interval_t [3:0] cand_set_t;

endpackage

// ==== src/extend_decide_stage.sv ====
`include "bwt_params.svh"

module extend_decide_stage (
	input  logic                     Clk_32UI,
	input  logic                     reset_BWT_extend,
	input  logic                     stall_i,
	input  pipe_pkg::fwd_req_t       req_i,
	input  bwt_types_pkg::cand_set_t cand_i,
	output pipe_pkg::curr_wr_t       curr_wr_o,
	output pipe_pkg::ret_t           ret_o,
	output pipe_pkg::upd_ctl_t       upd_o,
	output bwt_types_pkg::cand_set_t cand_o
);

	localparam logic [`BWT_PTR_WIDTH-1:0] LEN = `BWT_LEN;

	logic [1:0]                  sel_idx;
	bwt_types_pkg::interval_t    sel;
	logic                        x2_differs;
	pipe_pkg::curr_wr_t          wr_n;
	pipe_pkg::ret_t              ret_n;
	pipe_pkg::upd_ctl_t          upd_n;

	// old interval goes to the curr queue at ptr_curr
	function automatic pipe_pkg::curr_wr_t curr_entry(input pipe_pkg::fwd_req_t r);
		pipe_pkg::curr_wr_t w;
		w.we       = 1'b1;
		w.read_num = r.read_num;
		w.addr     = r.ptr_curr;
		w.data     = {r.ik.info, r.ik.intv.x2, r.ik.intv.x1, r.ik.intv.x0};
		return w;
	endfunction

	assign sel_idx    = 2'd3 - req_i.query[1:0]; // candidates are stored reversed
	assign sel        = cand_i[sel_idx];
	assign x2_differs = sel.x2 != req_i.ik.intv.x2;

	// --------------------------------------------------
	// forward step decision
	// --------------------------------------------------
	always_comb begin
		wr_n         = '0;
		ret_n        = '0;
		upd_n.req    = req_i;
		upd_n.update = 1'b0;
		case (req_i.status)
			`BWT_ST_RUN: begin
				if (req_i.query > 8'd3) begin // ambiguous base ends the extension
					wr_n               = curr_entry(req_i);
					upd_n.req.ptr_curr = req_i.ptr_curr + 1'b1;
					upd_n.req.status   = `BWT_ST_BREAK;
				end else if (x2_differs) begin
					wr_n               = curr_entry(req_i);
					upd_n.req.ptr_curr = req_i.ptr_curr + 1'b1;
					if (sel.x2 < bwt_types_pkg::word_t'(req_i.min_intv)) begin
						upd_n.req.status = `BWT_ST_BREAK; // too few hits left
					end else begin
						upd_n.update = 1'b1;
					end
				end
			end
			`BWT_ST_BREAK: begin
				if (req_i.forward_i == LEN) begin // reached the read end
					wr_n               = curr_entry(req_i);
					upd_n.req.ptr_curr = req_i.ptr_curr + 1'b1;
				end
				ret_n.valid      = 1'b1;
				ret_n.read_num   = req_i.read_num;
				ret_n.ret        = req_i.ik.info[`BWT_PTR_WIDTH-1:0];
				upd_n.req.status = `BWT_ST_BCK_INI;
			end
			default: begin
				upd_n.req = req_i; // other states just pass
			end
		endcase
	end

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			curr_wr_o    <= '0;
			ret_o        <= '0;
			upd_o.req    <= pipe_pkg::BUBBLE_REQ;
			upd_o.update <= 1'b0;
		end else if (!stall_i) begin
			curr_wr_o <= wr_n;
			ret_o     <= ret_n; // one cycle only
			upd_o     <= upd_n;
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (!stall_i) begin
			cand_o <= cand_i;
		end
	end

endmodule

// ==== src/extend_update_stage.sv ====
`include "bwt_params.svh"

module extend_update_stage (
	input  logic                     Clk_32UI,
	input  logic                     reset_BWT_extend,
	input  logic                     stall_i,
	input  pipe_pkg::upd_ctl_t       upd_i,
	input  bwt_types_pkg::cand_set_t cand_i,
	output pipe_pkg::fwd_req_t       req_o,
	output bwt_types_pkg::word_t     k_o,
	output bwt_types_pkg::word_t     l_o,
	output bwt_types_pkg::word_t     k_dec_o,
	output bwt_types_pkg::word_t     l_dec_o
);

	logic [1:0]               sel_idx;
	bwt_types_pkg::interval_t sel;
	pipe_pkg::fwd_req_t       req_n;
	bwt_types_pkg::word_t     k_n;
	bwt_types_pkg::word_t     l_n;

	assign sel_idx = 2'd3 - upd_i.req.query[1:0];
	assign sel     = cand_i[sel_idx];

	// --------------------------------------------------
	// ik = ok[c], ik.info = i + 1, i++
	// --------------------------------------------------
	always_comb begin
		req_n = upd_i.req;
		if (upd_i.req.status == `BWT_ST_RUN && upd_i.update) begin
			req_n.ik.intv  = sel;
			req_n.ik.info  = bwt_types_pkg::word_t'(upd_i.req.forward_i) + 1'b1;
			req_n.forward_i = upd_i.req.forward_i + 1'b1;
		end
	end

	// k and l of the next lookup, taken from the resulting interval
	assign k_n = req_n.ik.intv.x1 - 1'b1;
	assign l_n = k_n + req_n.ik.intv.x2;

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			req_o <= pipe_pkg::BUBBLE_REQ;
		end else if (!stall_i) begin
			req_o <= req_n;
		end
	end

	// decremented forms are ready so the next stage only picks one
	always_ff @(posedge Clk_32UI) begin
		if (!stall_i) begin
			k_o     <= k_n;
			l_o     <= l_n;
			k_dec_o <= k_n - 1'b1;
			l_dec_o <= l_n - 1'b1;
		end
	end

endmodule

// ==== src/mem_request_stage.sv ====
`include "bwt_params.svh"

module mem_request_stage (
	input  logic                 Clk_32UI,
	input  logic                 reset_BWT_extend,
	input  logic                 stall_i,
	input  pipe_pkg::fwd_req_t   req_i,
	input  bwt_types_pkg::word_t k_i,
	input  bwt_types_pkg::word_t l_i,
	input  bwt_types_pkg::word_t k_dec_i,
	input  bwt_types_pkg::word_t l_dec_i,
	input  bwt_types_pkg::word_t primary_i,
	output pipe_pkg::dram_req_t  dram_o,
	output pipe_pkg::fwd_req_t   next_req_o
);

	localparam int LINE_BITS = `BWT_LINE_HI - `BWT_LINE_LO + 1;
	localparam int PAD_BITS  = `BWT_ADDR_WIDTH - LINE_BITS;

	bwt_types_pkg::word_t k_corr;
	bwt_types_pkg::word_t l_corr;
	logic                 issue;

	function automatic logic [`BWT_ADDR_WIDTH-1:0] line_addr(input bwt_types_pkg::word_t v);
		return {v[`BWT_LINE_HI:`BWT_LINE_LO], {PAD_BITS{1'b0}}};
	endfunction

	// the primary row is not stored in the bwt
	assign k_corr = (k_i >= primary_i) ? k_dec_i : k_i;
	assign l_corr = (l_i >= primary_i) ? l_dec_i : l_i;
	assign issue  = req_i.status == `BWT_ST_INIT || req_i.status == `BWT_ST_RUN;

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			dram_o     <= '0;
			next_req_o <= pipe_pkg::BUBBLE_REQ;
		end else if (!stall_i) begin
			dram_o.valid  <= issue; // no lookup after break
			dram_o.addr_k <= issue ? line_addr(k_corr) : '0;
			dram_o.addr_l <= issue ? line_addr(l_corr) : '0;
			next_req_o    <= req_i;
			if (req_i.status == `BWT_ST_INIT) begin
				next_req_o.status <= `BWT_ST_RUN; // first lookup issued
			end
		end
	end

endmodule

// ==== src/occ_delay_line.sv ====
module occ_delay_line #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 2,
	parameter payload_t RESET_VAL = '0
) (
	input  logic     Clk_32UI,
	input  logic     reset_BWT_extend,
	input  logic     stall_i,
	input  payload_t d_i,
	output payload_t q_o
);

	payload_t stage_q [DEPTH]; // stage 0 is the input end

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			for (int i = 0; i < DEPTH; i++) begin
				stage_q[i] <= RESET_VAL; // slots drain as empty entries
			end
		end else if (!stall_i) begin
			stage_q[0] <= d_i;
			for (int i = 1; i < DEPTH; i++) begin
				stage_q[i] <= stage_q[i-1];
			end
		end
	end

	assign q_o = stage_q[DEPTH-1];

endmodule

// ==== src/pipe_pkg.sv ====
`include "bwt_params.svh"

package pipe_pkg;

	// --------------------------------------------------
	// request record travelling down the pipeline
	// --------------------------------------------------
	typedef struct packed {
		bwt_types_pkg::status_t              status;
		logic [`BWT_QUERY_WIDTH-1:0]         query;    // current query base
		logic [`BWT_PTR_WIDTH-1:0]           ptr_curr; // next free curr queue slot
		logic [`BWT_READ_NUM_WIDTH-1:0]      read_num;
		bwt_types_pkg::ik_t                  ik;
		logic [`BWT_PTR_WIDTH-1:0]           forward_i;
		logic [`BWT_PTR_WIDTH-1:0]           min_intv;
	} fwd_req_t;

	// write port of the current-interval queue
	typedef struct packed {
		logic                                we;
		logic [`BWT_READ_NUM_WIDTH-1:0]      read_num;
		logic [`BWT_PTR_WIDTH-1:0]           addr;
		logic [4*`BWT_WORD_WIDTH-1:0]        data; // info, x2, x1, x0
	} curr_wr_t;

	// end of forward search for one read
	typedef struct packed {
		logic                                valid;
		logic [`BWT_READ_NUM_WIDTH-1:0]      read_num;
		logic [`BWT_PTR_WIDTH-1:0]           ret;
	} ret_t;

	// decide -> update
	typedef struct packed {
		fwd_req_t                            req;
		logic                                update; // take the selected candidate
	} upd_ctl_t;

	// line requests for the next occurrence lookup
	typedef struct packed {
		logic                                valid;
		logic [`BWT_ADDR_WIDTH-1:0]          addr_k;
		logic [`BWT_ADDR_WIDTH-1:0]          addr_l;
	} dram_req_t;

	localparam fwd_req_t BUBBLE_REQ = '{
		status:    `BWT_ST_BUBBLE,
		query:     '0,
		ptr_curr:  '0,
		read_num:  '0,
		ik:        '0,
		forward_i: '0,
		min_intv:  '0
	};

endpackage

// ==== verification/bwt_forward_tb.sv ====
`include "bwt_params.svh"

module bwt_forward_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NF           = 38; // words per test line
	localparam int MAX_TESTS    = 32;
	localparam int RESET_CYCLES = 16;
	localparam int TEST_CYCLES  = 40;

	logic                     Clk_32UI;
	logic                     reset_BWT_extend;
	logic                     stall_i;
	pipe_pkg::fwd_req_t       req_i;
	bwt_types_pkg::word_t     primary_i;
	bwt_types_pkg::cand_set_t cand_i;
	pipe_pkg::curr_wr_t       curr_wr_o;
	pipe_pkg::ret_t           ret_o;
	pipe_pkg::dram_req_t      dram_o;
	pipe_pkg::fwd_req_t       next_req_o;

	logic [63:0] vec [MAX_TESTS*NF]; // test lines, one after the other
	int          num_tests;
	int          err_cnt;
	int          pass_cnt;
	logic        test_fail;
	logic        loaded;

	bwt_forward_top bwt_forward_top_i (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.stall_i          (stall_i),
		.req_i            (req_i),
		.primary_i        (primary_i),
		.cand_i           (cand_i),
		.curr_wr_o        (curr_wr_o),
		.ret_o            (ret_o),
		.dram_o           (dram_o),
		.next_req_o       (next_req_o)
	);

	initial begin
		Clk_32UI = 1'b0;
		forever #4 Clk_32UI = ~Clk_32UI; // 8 ns period
	end

	task automatic compare_value(input string what, input logic [255:0] got,
		input logic [255:0] want);
		if (got !== want) begin
			$display("ERR %0d ns: %s is %0h, expected %0h", $time, what, got, want);
			err_cnt++;
			test_fail = 1'b1;
		end
	endtask

	task automatic log_result(input string name);
		$display("%s: %s", name, test_fail ? "mismatch" : "ok");
		if (!test_fail) pass_cnt++;
	endtask

	// --------------------------------------------------
	// one request through the pipe, edges counted without stalls
	// --------------------------------------------------
	task automatic run_test(input int t);
		logic [63:0]              f [NF];
		pipe_pkg::fwd_req_t       req;
		bwt_types_pkg::cand_set_t cand;
		int                       adv;
		int                       stall_left;
		for (int k = 0; k < NF; k++) f[k] = vec[t*NF + k];
		req.status    = f[2][5:0];
		req.query     = f[3][7:0];
		req.ptr_curr  = f[4][6:0];
		req.read_num  = f[5][7:0];
		req.ik.intv   = {f[6], f[7], f[8]}; // x0, x1, x2
		req.ik.info   = f[9];
		req.forward_i = f[10][6:0];
		req.min_intv  = f[11][6:0];
		for (int j = 0; j < 4; j++) cand[j] = {f[13+3*j], f[14+3*j], f[15+3*j]};
		test_fail  = 1'b0;
		adv        = 0;
		stall_left = int'(f[1]);
		while (adv <= 16) begin
			@(negedge Clk_32UI);
			stall_i = 1'b0;
			if (stall_left > 0 && adv == int'(f[0])) begin
				stall_i = 1'b1;
				stall_left--;
			end
			req_i     = (adv == 0) ? req : pipe_pkg::BUBBLE_REQ;
			cand_i    = (adv >= 13) ? cand : '0; // held through any stall
			primary_i = f[12];
			if (adv == 14) begin
				compare_value("curr we", curr_wr_o.we, f[25]);
				if (f[25][0]) begin // old interval at ptr_curr
					compare_value("curr addr", curr_wr_o.addr, f[4]);
					compare_value("curr read_num", curr_wr_o.read_num, f[5]);
					compare_value("curr data", curr_wr_o.data, {f[9], f[8], f[7], f[6]});
				end
				compare_value("ret valid", ret_o.valid, f[26]);
				if (f[26][0]) begin
					compare_value("ret value", ret_o.ret, f[27]);
					compare_value("ret read_num", ret_o.read_num, f[5]);
				end
			end
			if (adv == 15) begin
				compare_value("ret pulse width", ret_o.valid, 1'b0);
				compare_value("curr we after", curr_wr_o.we, 1'b0);
			end
			if (adv == 16) begin
				compare_value("dram valid", dram_o.valid, f[28]);
				compare_value("dram addr_k", dram_o.addr_k, f[29]);
				compare_value("dram addr_l", dram_o.addr_l, f[30]);
				compare_value("next status", next_req_o.status, f[31]);
				compare_value("next query", next_req_o.query, f[3]);
				compare_value("next ptr", next_req_o.ptr_curr, f[32]);
				compare_value("next read_num", next_req_o.read_num, f[5]);
				compare_value("next interval", next_req_o.ik.intv, {f[33], f[34], f[35]});
				compare_value("next info", next_req_o.ik.info, f[36]);
				compare_value("next forward_i", next_req_o.forward_i, f[37]);
				compare_value("next min_intv", next_req_o.min_intv, f[11]);
			end
			@(posedge Clk_32UI);
			if (!stall_i) adv++;
		end
		log_result($sformatf("test %0d", t + 1));
	endtask

	initial begin
		reset_BWT_extend = 1'b0;
		stall_i          = 1'b0;
		req_i            = pipe_pkg::BUBBLE_REQ;
		primary_i        = '0;
		cand_i           = '0;
		err_cnt          = 0;
		pass_cnt         = 0;
		num_tests        = 0;
		test_fail        = 1'b0;
		for (int i = 0; i < MAX_TESTS*NF; i++) vec[i] = '1; // all ones marks the end
		$readmemh("verification/forward_tests.txt", vec);
		while (num_tests < MAX_TESTS && vec[num_tests*NF] != '1) num_tests++;
		loaded = 1'b1;
		if (num_tests == 0) begin
			$display("no test lines could be read from the test file");
			err_cnt++;
		end
		repeat (RESET_CYCLES) @(negedge Clk_32UI);
		compare_value("reset curr we", curr_wr_o.we, 1'b0);
		compare_value("reset ret valid", ret_o.valid, 1'b0);
		compare_value("reset dram valid", dram_o.valid, 1'b0);
		compare_value("reset next status", next_req_o.status, `BWT_ST_BUBBLE);
		log_result("reset");
		reset_BWT_extend = 1'b1;
		for (int t = 0; t < num_tests; t++) run_test(t);
		$display("%0d of %0d tests ok, %0d mismatches", pass_cnt, num_tests + 1, err_cnt);
		if (err_cnt == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// --------------------------------------------------
	// watchdog
	// --------------------------------------------------
	initial begin
		wait (loaded === 1'b1);
		repeat (num_tests * TEST_CYCLES + RESET_CYCLES + TEST_CYCLES) @(posedge Clk_32UI);
		$display("the run did not finish in time and was stopped by the watchdog");
		$display("tests failed");
		$finish;
	end

endmodule

// ==== verification/forward_tests.txt ====
// stall_at stall_len | status query ptr read_num x0 x1 x2 info fwd min_intv | primary
// ok0..ok3 as x0 x1 x2 | we ret_v ret dram_v addr_k addr_l | status ptr x0 x1 x2 info fwd
0 0 1 0 3 11 100 2000 80 20 20 10 1480 10 1100 5 20 1201 30 30 1300 7 40 1480 81 1 0 0 1 280 290 1 4 40 1480 81 21 21
0 0 1 2 5 22 200 3000 90 40 40 8 1000 10 1100 5 20 1201 30 30 1300 7 40 1480 81 1 0 0 1 230 240 1 6 20 1201 30 41 41
0 0 1 1 7 33 300 4000 60 15 15 10 5000 10 1100 5 20 1201 30 30 1300 7 40 1480 81 1 0 0 0 0 0 2 8 300 4000 60 15 15
0 0 1 3 9 44 500 6000 5 30 30 2 5000 10 1100 5 20 1201 30 30 1300 7 40 1480 81 0 0 0 1 bf0 c00 1 9 500 6000 5 30 30
0 0 2 0 a 55 700 7000 20 da 65 10 5000 10 1100 5 20 1201 30 30 1300 7 40 1480 81 1 1 5a 0 0 0 4 b 700 7000 20 da 65
0 0 2 0 c 66 800 8000 21 33 30 10 5000 10 1100 5 20 1201 30 30 1300 7 40 1480 81 0 1 33 0 0 0 4 c 800 8000 21 33 30
0 0 0 2 1 77 0 1 1000 0 0 10 800 10 1100 5 20 1201 30 30 1300 7 40 1480 81 0 0 0 1 0 1f0 1 1 0 1 1000 0 0
0 0 1 4 10 88 900 9000 44 12 12 10 5000 10 1100 5 20 1201 30 30 1300 7 40 1480 81 1 0 0 0 0 0 2 11 900 9000 44 12 12
d 5 1 0 14 99 a00 a000 80 22 22 10 1480 10 1100 5 20 1201 30 30 1300 7 40 1480 81 1 0 0 1 280 290 1 15 40 1480 81 23 23
e 5 1 2 1e aa b00 b000 90 50 50 8 1000 10 1100 5 20 1201 30 30 1300 7 40 1480 81 1 0 0 1 230 240 1 1f 20 1201 30 51 51
